/* hw/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// major opcodes
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_BRANCH  7'b1100011
`define OPC_STORE   7'b0100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// funct3, OP and OP-IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3, branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct3, stores and jalr
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010
`define F3_JALR     3'b000

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // sub, sra

`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_XOR     4'd2
`define ALU_OR      4'd3
`define ALU_AND     4'd4
`define ALU_SLT     4'd5
`define ALU_SLTU    4'd6
`define ALU_SLL     4'd7
`define ALU_SRL     4'd8
`define ALU_SRA     4'd9
`define ALU_PASS    4'd10  // op1 straight through, lui

`define BR_EQ       3'd0
`define BR_NE       3'd1
`define BR_LT       3'd2
`define BR_GE       3'd3
`define BR_LTU      3'd4
`define BR_GEU      3'd5

`define ST_BYTE     2'd0
`define ST_HALF     2'd1
`define ST_WORD     2'd2

`endif

/* hw/ex_pkg.sv */
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [(`XLEN/8)-1:0]   byte_sel_t;  // one bit per byte lane
    typedef logic [3:0]             alu_sel_t;
    typedef logic [2:0]             br_cond_t;
    typedef logic [1:0]             st_size_t;

    typedef struct packed {
        word_t     inst;
        word_t     op1;
        word_t     op2;
        reg_addr_t rd_addr;
        word_t     base_addr;
        word_t     addr_offset;
    } ex_in_t;

    typedef struct packed {
        logic     wb_en;
        alu_sel_t alu_sel;
        logic     branch;
        br_cond_t br_cond;
        logic     jump;     // jal, jalr
        logic     store;
        st_size_t st_size;
    } ex_ctrl_t;

    typedef struct packed {
        logic eq;
        logic lt;   // signed
        logic ltu;
    } cmp_flags_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd_addr;
        word_t     data;
    } wb_req_t;

    typedef struct packed {
        logic  en;
        word_t target;
    } jump_req_t;

    typedef struct packed {
        logic      req;
        byte_sel_t sel;
        word_t     addr;
        word_t     data;
    } store_req_t;

endpackage

/* hw/ex_decode.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_decode (
    input  ex_pkg::word_t    inst_i,
    output ex_pkg::ex_ctrl_t ctrl_o
);

    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_sel_t   arith_sel;  // common to OP and OP-IMM
    logic       f7_ok;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // only add/sub care about the full funct7
    assign f7_ok = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);

    always_comb begin
        case (funct3)
            `F3_ADD_SUB: arith_sel = `ALU_ADD;
            `F3_SLL:     arith_sel = `ALU_SLL;
            `F3_SLT:     arith_sel = `ALU_SLT;
            `F3_SLTU:    arith_sel = `ALU_SLTU;
            `F3_XOR:     arith_sel = `ALU_XOR;
            `F3_SR:      arith_sel = funct7[5] ? `ALU_SRA : `ALU_SRL;
            `F3_OR:      arith_sel = `ALU_OR;
            default:     arith_sel = `ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            `OPC_OP_IMM: begin
                ctrl_o.wb_en   = 1'b1;
                ctrl_o.alu_sel = arith_sel;  // addi ignores funct7, it is imm
            end
            `OPC_OP: begin
                if (funct3 != `F3_ADD_SUB) begin
                    ctrl_o.wb_en   = 1'b1;
                    ctrl_o.alu_sel = arith_sel;
                end else if (f7_ok) begin
                    ctrl_o.wb_en   = 1'b1;
                    ctrl_o.alu_sel = funct7[5] ? `ALU_SUB : `ALU_ADD;
                end
            end
            `OPC_BRANCH: begin
                ctrl_o.branch = 1'b1;
                case (funct3)
                    `F3_BEQ:  ctrl_o.br_cond = `BR_EQ;
                    `F3_BNE:  ctrl_o.br_cond = `BR_NE;
                    `F3_BLT:  ctrl_o.br_cond = `BR_LT;
                    `F3_BGE:  ctrl_o.br_cond = `BR_GE;
                    `F3_BLTU: ctrl_o.br_cond = `BR_LTU;
                    `F3_BGEU: ctrl_o.br_cond = `BR_GEU;
                    default:  ctrl_o.branch  = 1'b0;  // 010, 011 undefined
                endcase
            end
            `OPC_STORE: begin
                ctrl_o.store = 1'b1;
                case (funct3)
                    `F3_SB:  ctrl_o.st_size = `ST_BYTE;
                    `F3_SH:  ctrl_o.st_size = `ST_HALF;
                    `F3_SW:  ctrl_o.st_size = `ST_WORD;
                    default: ctrl_o.store   = 1'b0;
                endcase
            end
            `OPC_JAL: begin
                ctrl_o.wb_en   = 1'b1;
                ctrl_o.jump    = 1'b1;
                ctrl_o.alu_sel = `ALU_ADD;  // link value op1 + op2
            end
            `OPC_JALR: begin
                if (funct3 == `F3_JALR) begin
                    ctrl_o.wb_en   = 1'b1;
                    ctrl_o.jump    = 1'b1;
                    ctrl_o.alu_sel = `ALU_ADD;
                end
            end
            `OPC_LUI: begin
                ctrl_o.wb_en   = 1'b1;
                ctrl_o.alu_sel = `ALU_PASS;
            end
            `OPC_AUIPC: begin
                ctrl_o.wb_en   = 1'b1;
                ctrl_o.alu_sel = `ALU_ADD;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

/* hw/ex_alu.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_alu (
    input  ex_pkg::word_t      op1_i,
    input  ex_pkg::word_t      op2_i,
    input  ex_pkg::alu_sel_t   alu_sel_i,
    output ex_pkg::word_t      result_o,
    output ex_pkg::cmp_flags_t flags_o
);

    import ex_pkg::*;

    logic [$clog2(`XLEN)-1:0] shamt;
    word_t sum;
    word_t diff;
    word_t srl_res;
    word_t sra_mask;
    word_t sign_fill;
    logic  eq;
    logic  lt;
    logic  ltu;

    assign shamt = op2_i[4:0];  // rs2 low bits or I-type shamt

    assign sum     = op1_i + op2_i;
    assign diff    = op1_i - op2_i;
    assign srl_res = op1_i >> shamt;

    // ones where shifted data lands, zeros where sign must go
    assign sra_mask  = {`XLEN{1'b1}} >> shamt;
    assign sign_fill = {`XLEN{op1_i[`XLEN-1]}} & ~sra_mask;

    assign eq  = (op1_i == op2_i);
    assign lt  = ($signed(op1_i) < $signed(op2_i));
    assign ltu = (op1_i < op2_i);

    // also consumed by branch evaluation
    assign flags_o = '{eq: eq, lt: lt, ltu: ltu};

    always_comb begin
        case (alu_sel_i)
            `ALU_ADD:  result_o = sum;
            `ALU_SUB:  result_o = diff;
            `ALU_XOR:  result_o = op1_i ^ op2_i;
            `ALU_OR:   result_o = op1_i | op2_i;
            `ALU_AND:  result_o = op1_i & op2_i;
            `ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt};
            `ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, ltu};
            `ALU_SLL:  result_o = op1_i << shamt;
            `ALU_SRL:  result_o = srl_res;
            `ALU_SRA:  result_o = srl_res | sign_fill;
            `ALU_PASS: result_o = op1_i;
            default:   result_o = '0;
        endcase
    end

endmodule

/* hw/ex_branch.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_branch (
    input  ex_pkg::ex_ctrl_t   ctrl_i,
    input  ex_pkg::cmp_flags_t flags_i,
    input  ex_pkg::word_t      target_i,
    output ex_pkg::jump_req_t  jump_o
);

    import ex_pkg::*;

    logic      cond_met;
    jump_req_t jump;

    always_comb begin
        case (ctrl_i.br_cond)
            `BR_EQ:  cond_met = flags_i.eq;
            `BR_NE:  cond_met = ~flags_i.eq;
            `BR_LT:  cond_met = flags_i.lt;
            `BR_GE:  cond_met = ~flags_i.lt;
            `BR_LTU: cond_met = flags_i.ltu;
            `BR_GEU: cond_met = ~flags_i.ltu;
            default: cond_met = 1'b0;
        endcase
    end

    always_comb begin
        jump.en     = ctrl_i.jump | (ctrl_i.branch & cond_met);
        jump.target = jump.en ? target_i : '0;  // zero when not taken
    end

    assign jump_o = jump;

endmodule

/* hw/ex_store.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_store (
    input  logic               store_i,
    input  ex_pkg::st_size_t   size_i,
    input  ex_pkg::word_t      addr_i,
    input  ex_pkg::word_t      data_i,
    output ex_pkg::store_req_t store_o
);

    import ex_pkg::*;

    logic [4:0] byte_shift;  // bit offset of the addressed byte lane
    byte_sel_t  byte_sel;
    word_t      byte_data;

    assign byte_shift = {addr_i[1:0], 3'b000};
    assign byte_sel   = byte_sel_t'(4'b0001) << addr_i[1:0];
    assign byte_data  = word_t'(data_i[7:0]) << byte_shift;

    always_comb begin
        store_o = '0;
        if (store_i) begin
            store_o.req  = 1'b1;
            store_o.addr = addr_i;
            case (size_i)
                `ST_BYTE: begin
                    store_o.sel  = byte_sel;
                    store_o.data = byte_data;
                end
                `ST_HALF: begin
                    // lane from addr bit 1, bit 0 ignored
                    if (addr_i[1]) begin
                        store_o.sel  = 4'b1100;
                        store_o.data = {data_i[15:0], 16'b0};
                    end else begin
                        store_o.sel  = 4'b0011;
                        store_o.data = {16'b0, data_i[15:0]};
                    end
                end
                `ST_WORD: begin
                    store_o.sel  = 4'b1111;
                    store_o.data = data_i;
                end
                default: store_o = '0;
            endcase
        end
    end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  ex_pkg::ex_in_t     ex_in_i,
    output ex_pkg::wb_req_t    wb_o,
    output ex_pkg::jump_req_t  jump_o,
    output ex_pkg::store_req_t store_o
);

    import ex_pkg::*;

    ex_ctrl_t   ctrl;
    word_t      eff_addr;
    word_t      alu_res;
    cmp_flags_t flags;
    wb_req_t    wb_d;
    jump_req_t  jump_d;
    store_req_t store_d;

    // shared by branch/jump target and store address
    assign eff_addr = ex_in_i.base_addr + ex_in_i.addr_offset;

    ex_decode i_decode (
        .inst_i (ex_in_i.inst),
        .ctrl_o (ctrl)
    );

    ex_alu i_alu (
        .op1_i     (ex_in_i.op1),
        .op2_i     (ex_in_i.op2),
        .alu_sel_i (ctrl.alu_sel),
        .result_o  (alu_res),
        .flags_o   (flags)
    );

    ex_branch i_branch (
        .ctrl_i   (ctrl),
        .flags_i  (flags),
        .target_i (eff_addr),
        .jump_o   (jump_d)
    );

    ex_store i_store (
        .store_i (ctrl.store),
        .size_i  (ctrl.st_size),
        .addr_i  (eff_addr),
        .data_i  (ex_in_i.op2),  // rs2 value
        .store_o (store_d)
    );

    always_comb begin
        wb_d = '0;
        if (ctrl.wb_en) begin
            wb_d.en      = 1'b1;
            wb_d.rd_addr = ex_in_i.rd_addr;
            wb_d.data    = alu_res;
        end
    end

    // one register stage on all results
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_o    <= '0;
            jump_o  <= '0;
            store_o <= '0;
        end else begin
            wb_o    <= wb_d;
            jump_o  <= jump_d;
            store_o <= store_d;
        end
    end

endmodule

/* tb/ex_ref_model.svh */
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected writeback from the instruction rules
function automatic wb_req_t expect_wb(input ex_in_t x);
    wb_req_t    w;
    logic [6:0] opc;
    logic [6:0] f7;
    logic       ok;
    word_t      r;
    opc = x.inst[6:0];
    f7  = x.inst[31:25];
    ok  = 1'b1;
    r   = x.op1 + x.op2;  // add, link value, auipc
    case (opc)
        `OPC_OP, `OPC_OP_IMM: begin
            case (x.inst[14:12])
                `F3_ADD_SUB: begin
                    if (opc == `OPC_OP && f7 == `F7_ALT)
                        r = x.op1 - x.op2;
                    else if (opc == `OPC_OP && f7 != `F7_BASE)
                        ok = 1'b0;
                end
                `F3_SLL:  r = x.op1 << x.op2[4:0];
                `F3_SLT:  r = {31'b0, $signed(x.op1) < $signed(x.op2)};
                `F3_SLTU: r = {31'b0, x.op1 < x.op2};
                `F3_XOR:  r = x.op1 ^ x.op2;
                `F3_OR:   r = x.op1 | x.op2;
                `F3_AND:  r = x.op1 & x.op2;
                default: begin  // srl, sra
                    if (f7[5])
                        r = $signed(x.op1) >>> x.op2[4:0];
                    else
                        r = x.op1 >> x.op2[4:0];
                end
            endcase
        end
        `OPC_JAL, `OPC_AUIPC: ok = 1'b1;
        `OPC_JALR: ok = (x.inst[14:12] == `F3_JALR);
        `OPC_LUI:  r = x.op1;
        default:   ok = 1'b0;
    endcase
    w = '0;
    if (ok) begin
        w.en      = 1'b1;
        w.rd_addr = x.rd_addr;
        w.data    = r;
    end
    return w;
endfunction

function automatic jump_req_t expect_jump(input ex_in_t x);
    jump_req_t j;
    logic      take;
    case (x.inst[6:0])
        `OPC_BRANCH: begin
            case (x.inst[14:12])
                `F3_BEQ:  take = (x.op1 == x.op2);
                `F3_BNE:  take = (x.op1 != x.op2);
                `F3_BLT:  take = ($signed(x.op1) < $signed(x.op2));
                `F3_BGE:  take = ($signed(x.op1) >= $signed(x.op2));
                `F3_BLTU: take = (x.op1 < x.op2);
                `F3_BGEU: take = (x.op1 >= x.op2);
                default:  take = 1'b0;
            endcase
        end
        `OPC_JAL:  take = 1'b1;
        `OPC_JALR: take = (x.inst[14:12] == `F3_JALR);
        default:   take = 1'b0;
    endcase
    j = '0;
    if (take) begin
        j.en     = 1'b1;
        j.target = x.base_addr + x.addr_offset;
    end
    return j;
endfunction

function automatic store_req_t expect_store(input ex_in_t x);
    store_req_t s;
    word_t      ea;
    s  = '0;
    ea = x.base_addr + x.addr_offset;
    if (x.inst[6:0] == `OPC_STORE && x.inst[14:12] <= `F3_SW) begin
        s.req  = 1'b1;
        s.addr = ea;
        case (x.inst[14:12])
            `F3_SB: begin
                s.sel = {ea[1:0] == 2'd3, ea[1:0] == 2'd2, ea[1:0] == 2'd1, ea[1:0] == 2'd0};
                case (ea[1:0])
                    2'd0:    s.data = {24'b0, x.op2[7:0]};
                    2'd1:    s.data = {16'b0, x.op2[7:0], 8'b0};
                    2'd2:    s.data = {8'b0, x.op2[7:0], 16'b0};
                    default: s.data = {x.op2[7:0], 24'b0};
                endcase
            end
            `F3_SH: begin
                s.sel  = ea[1] ? 4'b1100 : 4'b0011;
                s.data = ea[1] ? {x.op2[15:0], 16'b0} : {16'b0, x.op2[15:0]};
            end
            default: begin
                s.sel  = 4'b1111;
                s.data = x.op2;
            end
        endcase
    end
    return s;
endfunction

`endif

/* tb/ex_stage_tb.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb;

    import ex_pkg::*;

    localparam int N_INST       = 200;
    localparam int N_RAND_TESTS = 4;
    localparam int RESET_CYCLES = 4;
    // twice the expected run length
    localparam int TIMEOUT_CYCLES = 2 * (N_RAND_TESTS * (N_INST + 1) + RESET_CYCLES + 1);

    logic       clk_i;
    logic       rst_n_i;
    ex_in_t     ex_in_i;
    wb_req_t    wb_o;
    jump_req_t  jump_o;
    store_req_t store_o;

    wb_req_t    exp_wb;
    jump_req_t  exp_jump;
    store_req_t exp_store;
    word_t      lcg_state = 32'd53931;
    int         cycles = 0;
    int         test_errs = 0;
    int         pass_count = 0;
    int         fail_count = 0;

    `include "ex_ref_model.svh"

    ex_stage i_dut (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ex_in_i (ex_in_i),
        .wb_o    (wb_o),
        .jump_o  (jump_o),
        .store_o (store_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // two lcg steps, upper halves only
    function automatic word_t rand_word();
        word_t hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    task automatic check_outputs();
        if (wb_o !== exp_wb) begin
            $display("ERROR %0t: wb_o expected %h, got %h", $time, exp_wb, wb_o);
            test_errs++;
        end
        if (jump_o !== exp_jump) begin
            $display("ERROR %0t: jump_o expected %h, got %h", $time, exp_jump, jump_o);
            test_errs++;
        end
        if (store_o !== exp_store) begin
            $display("ERROR %0t: store_o expected %h, got %h", $time, exp_store, store_o);
            test_errs++;
        end
    endtask

    // kind 1 alu, 2 branch, 3 jump/lui/auipc, else store
    task automatic drive_random(input int kind);
        ex_in_t     x;
        word_t      r;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        r             = rand_word();
        x.op1         = rand_word();
        x.op2         = (r[6:4] == 3'd0) ? x.op1 : rand_word();  // some equal pairs
        x.rd_addr     = r[31:27];
        x.base_addr   = rand_word();
        x.addr_offset = rand_word();
        f3            = r[10:8];
        f7            = `F7_BASE;
        case (kind)
            1: begin
                opc = r[12] ? `OPC_OP : `OPC_OP_IMM;
                if (r[11] && (f3 == `F3_ADD_SUB || f3 == `F3_SR))
                    f7 = `F7_ALT;
                if (r[3:0] == 4'd1) begin  // add/sub with a bad funct7
                    opc = `OPC_OP;
                    f3  = `F3_ADD_SUB;
                    f7  = r[22:16];
                end
            end
            2: opc = `OPC_BRANCH;  // f3 010, 011 show up as illegal
            3: begin
                case (r[13:12])
                    2'd0:    opc = `OPC_JAL;
                    2'd1:    opc = `OPC_JALR;
                    2'd2:    opc = `OPC_LUI;
                    default: opc = `OPC_AUIPC;
                endcase
                if (r[3:0] != 4'd1)
                    f3 = `F3_JALR;
            end
            default: begin
                opc = `OPC_STORE;
                if (r[3:0] != 4'd1)
                    f3 = r[9] ? `F3_SW : {2'b0, r[8]};
            end
        endcase
        x.inst = {f7, x.base_addr[24:15], f3, x.rd_addr, opc};
        if (r[3:0] == 4'd0)
            x.inst[6:0] = r[14] ? 7'b0000011 : 7'b1110011;  // load, system
        ex_in_i   = x;
        exp_wb    = expect_wb(x);
        exp_jump  = expect_jump(x);
        exp_store = expect_store(x);
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // one instruction per cycle, each checked a cycle after its drive
    task automatic run_test(input string name, input int kind);
        repeat (N_INST) begin
            @(negedge clk_i);
            check_outputs();
            drive_random(kind);
        end
        @(negedge clk_i);
        check_outputs();
        report_test(name);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        ex_in_i   = '0;
        exp_wb    = '0;
        exp_jump  = '0;
        exp_store = '0;
        repeat (RESET_CYCLES - 1) begin  // live inputs under reset
            @(negedge clk_i);
            check_outputs();
            drive_random(1);
            exp_wb    = '0;
            exp_jump  = '0;
            exp_store = '0;
        end
        @(negedge clk_i);
        check_outputs();
        rst_n_i = 1'b1;
        ex_in_i = '0;  // all-zero word decodes to nothing
        @(negedge clk_i);
        check_outputs();
        report_test("reset");
        run_test("alu writeback", 1);
        run_test("branches", 2);
        run_test("jumps lui auipc", 3);
        run_test("stores", 4);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* ex_stage.f */
+incdir+hw
+incdir+tb
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_store.sv
hw/ex_stage.sv
tb/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module ex_stage_tb -f ex_stage.f \
    -Mdir obj_dir -o ex_stage_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $build_log"
    exit 1
fi

./obj_dir/ex_stage_sim > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $sim_log"
    exit 1
fi
cat "$sim_log"

if grep -q "TEST RESULT: PASS" "$sim_log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $sim_log"
exit 1
